// ==== compile.f ====
+incdir+hdl
hdl/ahb_fe_pkg.sv
hdl/ahb_port_tracker.sv
hdl/ahb_grant_arbiter.sv
hdl/ahb_bus_mux.sv
hdl/ahb_multi_master.sv
verif/tb_ahb_multi_master.sv

// ==== hdl/ahb_bus_mux.sv ====
// AHB shared master port mux

`timescale 1ns/1ps

`include "ahb_fe_settings.svh"

module ahb_bus_mux (
	// Control from the arbiter and the trackers
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    gnt_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    dph_active_i,
	input  logic                                            bus_busy_i,

	// Requester fields
	input  logic [`AHB_FE_NUM_PORTS-1:0][`AHB_FE_ADDR_W-1:0] addr_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    write_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0][2:0]               size_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    priv_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0][`AHB_FE_DATA_W-1:0] wdata_i,

	// Shared AHB-Lite master signals
	output logic [`AHB_FE_ADDR_W-1:0]                       haddr_o,
	output logic                                            hwrite_o,
	output ahb_fe_pkg::htrans_t                             htrans_o,
	output ahb_fe_pkg::hsize_t                              hsize_o,
	output logic [3:0]                                      hprot_o,
	output ahb_fe_pkg::port_idx_t                           hmaster_o,
	output logic [`AHB_FE_DATA_W-1:0]                       hwdata_o
);

	import ahb_fe_pkg::*;

	localparam int NP = `AHB_FE_NUM_PORTS;

	logic [2:0] size_sel;
	logic       priv_sel;

	// -----------------------------------------------------------------------
	// Address phase select

	// AND-OR select, the grant is one-hot or zero
	always_comb begin
		haddr_o   = '0;
		hwrite_o  = 1'b0;
		size_sel  = '0;
		priv_sel  = 1'b0;
		hmaster_o = '0;
		for (int k = 0; k < NP; k++) begin
			haddr_o  = haddr_o | (addr_i[k] & {`AHB_FE_ADDR_W{gnt_i[k]}});
			hwrite_o = hwrite_o | (write_i[k] & gnt_i[k]);
			size_sel = size_sel | (size_i[k] & {3{gnt_i[k]}});
			priv_sel = priv_sel | (priv_i[k] & gnt_i[k]);
			if (gnt_i[k]) begin
				hmaster_o = hmaster_o | port_idx_t'(k);
			end
		end
	end

	assign hsize_o  = hsize_t'(size_sel);
	assign htrans_o = bus_busy_i ? HTRANS_NONSEQ : HTRANS_IDLE;

	// Noncacheable, nonbufferable, privilege from requester, data access
	assign hprot_o = {2'b00, priv_sel, 1'b1};

	// -----------------------------------------------------------------------
	// Write data from the data phase owner

	always_comb begin
		hwdata_o = '0;
		for (int k = 0; k < NP; k++) begin
			hwdata_o = hwdata_o | (wdata_i[k] & {`AHB_FE_DATA_W{dph_active_i[k]}});
		end
	end

	// Trackers each load their bit on the same edge
	always_comb begin
		a_dph_onehot: assert ($onehot0(dph_active_i))
			else $error("bus mux: more than one data phase owner");
	end

endmodule

// ==== hdl/ahb_fe_pkg.sv ====
// AHB front end shared types

`include "ahb_fe_settings.svh"

package ahb_fe_pkg;

	// -----------------------------------------------------------------------
	// AHB-Lite transfer encodings

	// Only IDLE and NONSEQ are issued, no bursts
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_t;

	// -----------------------------------------------------------------------
	// Requester numbering

	// Kept at least one bit wide for a single requester
	localparam int PORT_IDX_W =
		$clog2(`AHB_FE_NUM_PORTS > 1 ? `AHB_FE_NUM_PORTS : 2);

	// Also what goes out on hmaster
	typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage

// ==== hdl/ahb_fe_settings.svh ====
// AHB front end build settings

`ifndef AHB_FE_SETTINGS_SVH
`define AHB_FE_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Bus widths

// Byte address presented on haddr
`define AHB_FE_ADDR_W 32

// Width of hwdata and hrdata
`define AHB_FE_DATA_W 32

// ---------------------------------------------------------------------------
// Requesters sharing the master port
// Index 0 has the highest priority
`define AHB_FE_NUM_PORTS 3

`endif

// ==== hdl/ahb_grant_arbiter.sv ====
// AHB fixed priority grant arbiter

`timescale 1ns/1ps

`include "ahb_fe_settings.svh"

module ahb_grant_arbiter (
	input  logic                         clk,
	input  logic                         rst_n,

	// Pending address phases, one bit per requester
	input  logic [`AHB_FE_NUM_PORTS-1:0] req_i,

	// Data phase owner from the trackers
	input  logic [`AHB_FE_NUM_PORTS-1:0] dph_active_i,

	input  logic                         hready_i,
	input  logic                         hresp_i,

	// One-hot grant, or zero when nothing is requested
	output logic [`AHB_FE_NUM_PORTS-1:0] gnt_o,
	output logic                         bus_busy_o
);

	import ahb_fe_pkg::*;

	localparam int NP = `AHB_FE_NUM_PORTS;

	logic            hold_q;
	logic [NP-1:0]   gnt_prev_q;
	logic [NP-1:0]   eligible;
	logic [NP-1:0]   gnt_pri;
	logic            pick_vld;
	port_idx_t       pick_idx;

	// -----------------------------------------------------------------------
	// Grant hold over a stalled address phase

	// An error cancels the hold so the bus may go IDLE in the second cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_q     <= 1'b0;
			gnt_prev_q <= '0;
		end else begin
			hold_q     <= bus_busy_o && !hready_i && !hresp_i;
			gnt_prev_q <= gnt_o;
		end
	end

	// -----------------------------------------------------------------------
	// Priority pick

	// A port whose own data phase is still stalled cannot issue again yet
	assign eligible = req_i & ~(dph_active_i & {NP{!hready_i}});

	// Scan from the top so the lowest index wins
	always_comb begin
		pick_vld = 1'b0;
		pick_idx = '0;
		for (int k = NP - 1; k >= 0; k--) begin
			if (eligible[k]) begin
				pick_vld = 1'b1;
				pick_idx = port_idx_t'(k);
			end
		end
	end

	assign gnt_pri = pick_vld ? (NP'(1) << pick_idx) : '0;

	assign gnt_o      = hold_q ? gnt_prev_q : gnt_pri;
	assign bus_busy_o = |gnt_o;

	// -----------------------------------------------------------------------
	// Checks

	a_gnt_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt_o)
	) else $error("arbiter: grant is not one-hot");

	// Held grant stays on the same port, which keeps its request up
	a_gnt_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(bus_busy_o && !hready_i && !hresp_i) |=> ((gnt_o & req_i) == $past(gnt_o))
	) else $error("arbiter: grant changed during stalled address phase");

endmodule

// ==== hdl/ahb_multi_master.sv ====
// AHB multi-requester master front end

`timescale 1ns/1ps

`include "ahb_fe_settings.svh"

module ahb_multi_master (
	input  logic                                            clk,
	input  logic                                            rst_n,

	// ---------------------------------------------------------------------
	// Requester side, indexed by requester
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    req_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0][`AHB_FE_ADDR_W-1:0] addr_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    write_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0][2:0]               size_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0]                    priv_i,
	input  logic [`AHB_FE_NUM_PORTS-1:0][`AHB_FE_DATA_W-1:0] wdata_i,
	output logic [`AHB_FE_NUM_PORTS-1:0]                    aph_ready_o,
	output logic [`AHB_FE_NUM_PORTS-1:0]                    dph_ready_o,
	output logic [`AHB_FE_NUM_PORTS-1:0]                    dph_err_o,
	output logic [`AHB_FE_DATA_W-1:0]                       rdata_o,

	// ---------------------------------------------------------------------
	// AHB-Lite master port
	output logic [`AHB_FE_ADDR_W-1:0]                       haddr_o,
	output logic                                            hwrite_o,
	output ahb_fe_pkg::htrans_t                             htrans_o,
	output ahb_fe_pkg::hsize_t                              hsize_o,
	output logic [3:0]                                      hprot_o,
	output ahb_fe_pkg::port_idx_t                           hmaster_o,
	output logic [`AHB_FE_DATA_W-1:0]                       hwdata_o,
	input  logic                                            hready_i,
	input  logic                                            hresp_i,
	input  logic [`AHB_FE_DATA_W-1:0]                       hrdata_i
);

	logic [`AHB_FE_NUM_PORTS-1:0] gnt;
	logic [`AHB_FE_NUM_PORTS-1:0] dph_active;
	logic                         bus_busy;

	ahb_grant_arbiter arb0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_i        (req_i),
		.dph_active_i (dph_active),
		.hready_i     (hready_i),
		.hresp_i      (hresp_i),
		.gnt_o        (gnt),
		.bus_busy_o   (bus_busy)
	);

	// One tracker per requester
	for (genvar g = 0; g < `AHB_FE_NUM_PORTS; g++) begin : trk
		ahb_port_tracker u_tracker (
			.clk          (clk),
			.rst_n        (rst_n),
			.req_i        (req_i[g]),
			.gnt_i        (gnt[g]),
			.hready_i     (hready_i),
			.hresp_i      (hresp_i),
			.aph_ready_o  (aph_ready_o[g]),
			.dph_ready_o  (dph_ready_o[g]),
			.dph_err_o    (dph_err_o[g]),
			.dph_active_o (dph_active[g])
		);
	end

	ahb_bus_mux mux0 (
		.gnt_i        (gnt),
		.dph_active_i (dph_active),
		.bus_busy_i   (bus_busy),
		.addr_i       (addr_i),
		.write_i      (write_i),
		.size_i       (size_i),
		.priv_i       (priv_i),
		.wdata_i      (wdata_i),
		.haddr_o      (haddr_o),
		.hwrite_o     (hwrite_o),
		.htrans_o     (htrans_o),
		.hsize_o      (hsize_o),
		.hprot_o      (hprot_o),
		.hmaster_o    (hmaster_o),
		.hwdata_o     (hwdata_o)
	);

	// Read data is shared, each requester qualifies it with its own dph_ready
	assign rdata_o = hrdata_i;

endmodule

// ==== hdl/ahb_port_tracker.sv ====
// AHB requester data phase tracker

`timescale 1ns/1ps

`include "ahb_fe_settings.svh"

module ahb_port_tracker (
	input  logic clk,
	input  logic rst_n,

	// Requester address phase and its grant
	input  logic req_i,
	input  logic gnt_i,

	// Shared bus response
	input  logic hready_i,
	input  logic hresp_i,

	// Strobes back to the requester
	output logic aph_ready_o,
	output logic dph_ready_o,
	output logic dph_err_o,
	output logic dph_active_o
);

	// -----------------------------------------------------------------------
	// Data phase ownership

	logic dph_active_q;

	// Moves only when the bus advances, so a stalled data phase keeps its owner
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active_q <= 1'b0;
		end else if (hready_i) begin
			dph_active_q <= gnt_i && req_i;
		end
	end

	assign dph_active_o = dph_active_q;

	// -----------------------------------------------------------------------
	// Requester strobes

	// Address accepted in the cycle hready is seen high with our grant
	assign aph_ready_o = gnt_i && req_i && hready_i;

	assign dph_ready_o = dph_active_q && hready_i;

	// Error is passed on in both cycles of the two-cycle response, so the
	// requester sees it ahead of dph_ready
	assign dph_err_o = dph_active_q && hresp_i;

	// -----------------------------------------------------------------------
	// Checks

	// Grant only lands on a port that is still asking for the bus
	a_gnt_has_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		gnt_i |-> req_i
	) else $error("tracker: grant without request");

	// First error cycle is followed by the completing error cycle
	a_err_two_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		(dph_err_o && !hready_i) |=> (dph_err_o && dph_ready_o)
	) else $error("tracker: error response not two cycles");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AHB front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_ahb_multi_master \
	-f compile.f \
	-o sim_tb

# Keep going on a nonzero exit so the log can be searched
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// ==== verif/tb_ahb_multi_master.sv ====
// AHB multi-requester front end testbench

`timescale 1ns/1ps

`include "ahb_fe_settings.svh"

module tb_ahb_multi_master;

	import ahb_fe_pkg::*;

	localparam int NP       = `AHB_FE_NUM_PORTS;
	localparam int AW       = `AHB_FE_ADDR_W;
	localparam int DW       = `AHB_FE_DATA_W;
	localparam int XFERS    = 200;
	localparam int RST_CYC  = 16;
	localparam int WDOG_CYC = RST_CYC + NP * XFERS * 6;

	logic                  clk;
	logic                  rst_n;
	logic [NP-1:0]         req;
	logic [NP-1:0][AW-1:0] addr;
	logic [NP-1:0]         write;
	logic [NP-1:0][2:0]    size;
	logic [NP-1:0]         priv;
	logic [NP-1:0][DW-1:0] wdata;
	logic [NP-1:0]         aph_ready;
	logic [NP-1:0]         dph_ready;
	logic [NP-1:0]         dph_err;
	logic [DW-1:0]         rdata;
	logic [AW-1:0]         haddr;
	logic                  hwrite;
	htrans_t               htrans;
	hsize_t                hsize;
	logic [3:0]            hprot;
	port_idx_t             hmaster;
	logic [DW-1:0]         hwdata;
	logic                  hready;
	logic                  hresp;
	logic [DW-1:0]         hrdata;

	int seed       = 97;
	int finished   = 0;
	int xfer_count = 0;

	// Reference memory, 64 words
	logic [DW-1:0] mem [0:63];

	// Slave data phase state
	logic          s_valid;
	logic          s_write;
	logic          s_err;
	logic          s_err_first;
	int            s_wait;
	port_idx_t     s_port;
	logic [AW-1:0] s_addr;
	hsize_t        s_size;

	// Bus view of the previous cycle
	logic          p_busy;
	logic          p_hready;
	logic          p_hresp;
	logic          p_rst_n;
	port_idx_t     p_idx;
	logic [AW-1:0] p_addr;

	ahb_multi_master dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (req),
		.addr_i      (addr),
		.write_i     (write),
		.size_i      (size),
		.priv_i      (priv),
		.wdata_i     (wdata),
		.aph_ready_o (aph_ready),
		.dph_ready_o (dph_ready),
		.dph_err_o   (dph_err),
		.rdata_o     (rdata),
		.haddr_o     (haddr),
		.hwrite_o    (hwrite),
		.htrans_o    (htrans),
		.hsize_o     (hsize),
		.hprot_o     (hprot),
		.hmaster_o   (hmaster),
		.hwdata_o    (hwdata),
		.hready_i    (hready),
		.hresp_i     (hresp),
		.hrdata_i    (hrdata)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// -----------------------------------------------------------------------
	// Helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Byte lane update of one memory word
	function automatic logic [DW-1:0] merge_write(input logic [DW-1:0] old,
		input logic [DW-1:0] data, input logic [1:0] lane, input hsize_t sz);
		logic [DW-1:0] res;
		res = old;
		case (sz)
			HSIZE_BYTE: res[8*lane +: 8] = data[8*lane +: 8];
			HSIZE_HALF: res[16*lane[1] +: 16] = data[16*lane[1] +: 16];
			default:    res = data;
		endcase
		return res;
	endfunction

	// Aligned random access, about one in eight hits the error region
	task automatic new_request(input int k);
		int            sz;
		logic [AW-1:0] a;
		sz = rand_below(3);
		a = AW'(rand_below(64)) << 2;
		if (sz == 0) begin
			a[1:0] = 2'(rand_below(4));
		end else if (sz == 1) begin
			a[1] = 1'(rand_below(2));
		end
		if (rand_below(8) == 0) begin
			a[AW-1] = 1'b1;
		end
		req[k]   = 1'b1;
		addr[k]  = a;
		write[k] = 1'(rand_below(2));
		size[k]  = 3'(sz);
		priv[k]  = 1'(rand_below(2));
	endtask

	// -----------------------------------------------------------------------
	// Requester, may ask again while its own data phase is still open

	task automatic run_requester(input int k);
		int            issued;
		int            done;
		int            idle;
		logic          pend;
		logic          accepted;
		logic          fl_write;
		logic          fl_err;
		logic          saw_err;
		logic [AW-1:0] fl_addr;
		issued   = 0;
		done     = 0;
		idle     = 0;
		pend     = 1'b0;
		fl_write = 1'b0;
		fl_err   = 1'b0;
		saw_err  = 1'b0;
		fl_addr  = '0;
		while (done < XFERS) begin
			@(negedge clk);
			if (dph_ready[k]) begin
				// Error must be visible ahead of the ready strobe
				check_value($sformatf("dph_err_o[%0d] before ready", k),
					32'(saw_err), 32'(fl_err));
				if (!fl_write && !fl_err) begin
					check_value($sformatf("rdata_o[%0d]", k), rdata, mem[fl_addr[7:2]]);
				end
				done++;
				saw_err = 1'b0;
			end else if (dph_err[k]) begin
				saw_err = 1'b1;
			end
			accepted = aph_ready[k];
			if (accepted) begin
				fl_addr  = addr[k];
				fl_write = write[k];
				fl_err   = addr[k][AW-1];
				pend     = 1'b0;
			end
			@(posedge clk);
			#1;
			if (accepted) begin
				req[k]   = 1'b0;
				wdata[k] = DW'($random(seed));
			end
			if (!pend && issued < XFERS) begin
				if (idle > 0) begin
					idle--;
				end else begin
					new_request(k);
					pend = 1'b1;
					issued++;
					idle = rand_below(2);
				end
			end
		end
		finished++;
	endtask

	// -----------------------------------------------------------------------
	// Bus monitor and slave model, sampled mid-cycle

	task automatic observe_cycle();
		logic [NP-1:0] exp_aph;
		logic [NP-1:0] exp_rdy;
		logic [NP-1:0] exp_err;
		logic          held;
		logic          busy;
		port_idx_t     idx;
		exp_aph = '0;
		exp_rdy = '0;
		exp_err = '0;
		busy    = 1'b0;
		idx     = '0;
		if (!rst_n || !p_rst_n) begin
			check_value("htrans_o", 32'(htrans), 32'(HTRANS_IDLE));
			check_value("aph_ready_o", 32'(aph_ready), 32'h0);
			check_value("dph_ready_o", 32'(dph_ready), 32'h0);
			check_value("dph_err_o", 32'(dph_err), 32'h0);
		end
		if (rst_n) begin
			held = p_busy && !p_hready && !p_hresp;
			if (held) begin
				busy = 1'b1;
				idx  = p_idx;
				check_value("haddr_o held", haddr, p_addr);
			end else begin
				// Lowest index wins unless stuck in its own data phase
				for (int k = 0; k < NP; k++) begin
					if (!busy && req[k] &&
						!(s_valid && s_port == port_idx_t'(k) && !hready)) begin
						busy = 1'b1;
						idx  = port_idx_t'(k);
					end
				end
			end
			check_value("htrans_o", 32'(htrans),
				32'(busy ? HTRANS_NONSEQ : HTRANS_IDLE));
			if (busy) begin
				check_value("hmaster_o", 32'(hmaster), 32'(idx));
				check_value("haddr_o", haddr, addr[idx]);
				check_value("hwrite_o", 32'(hwrite), 32'(write[idx]));
				check_value("hsize_o", 32'(hsize), 32'(size[idx]));
				// Data access always, privileged bit when the requester asks
				check_value("hprot_o", 32'(hprot), priv[idx] ? 32'h3 : 32'h1);
				exp_aph[idx] = hready;
			end
			if (s_valid) begin
				exp_rdy[s_port] = hready;
				exp_err[s_port] = hresp;
			end
			check_value("aph_ready_o", 32'(aph_ready), 32'(exp_aph));
			check_value("dph_ready_o", 32'(dph_ready), 32'(exp_rdy));
			check_value("dph_err_o", 32'(dph_err), 32'(exp_err));

			if (hready) begin
				if (s_valid && s_write && !s_err) begin
					check_value("hwdata_o", hwdata, wdata[s_port]);
					mem[s_addr[7:2]] = merge_write(mem[s_addr[7:2]], wdata[s_port],
						s_addr[1:0], s_size);
				end
				s_valid = (htrans == HTRANS_NONSEQ);
				if (s_valid) begin
					s_addr      = haddr;
					s_write     = hwrite;
					s_size      = hsize;
					s_port      = hmaster;
					s_err       = haddr[AW-1];
					s_err_first = 1'b1;
					s_wait      = rand_below(4);
					xfer_count++;
				end
			end else if (s_valid) begin
				if (s_err) begin
					s_err_first = 1'b0;
				end else begin
					s_wait--;
				end
			end
		end
		p_busy   = busy;
		p_hready = hready;
		p_hresp  = hresp;
		p_idx    = idx;
		p_addr   = haddr;
		p_rst_n  = rst_n;
	endtask

	task automatic drive_response();
		if (!s_valid) begin
			hready = 1'b1;
			hresp  = 1'b0;
		end else if (s_err) begin
			// Two-cycle error response
			hready = !s_err_first;
			hresp  = 1'b1;
		end else begin
			hready = (s_wait == 0);
			hresp  = 1'b0;
		end
		if (s_valid && !s_write && !s_err && s_wait == 0) begin
			hrdata = mem[s_addr[7:2]];
		end else begin
			hrdata = DW'($random(seed));
		end
	endtask

	initial begin
		hready      = 1'b1;
		hresp       = 1'b0;
		hrdata      = '0;
		s_valid     = 1'b0;
		s_write     = 1'b0;
		s_err       = 1'b0;
		s_err_first = 1'b0;
		s_wait      = 0;
		s_port      = '0;
		s_addr      = '0;
		s_size      = HSIZE_WORD;
		p_busy      = 1'b0;
		p_hready    = 1'b1;
		p_hresp     = 1'b0;
		p_rst_n     = 1'b0;
		p_idx       = '0;
		p_addr      = '0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = {16'hc0de, 16'(i * 4)};
		end
		forever begin
			@(negedge clk);
			observe_cycle();
			@(posedge clk);
			#1;
			drive_response();
		end
	end

	// -----------------------------------------------------------------------
	// Main sequence and watchdog

	initial begin
		rst_n = 1'b0;
		req   = '0;
		addr  = '0;
		write = '0;
		size  = '0;
		priv  = '0;
		wdata = '0;
		repeat (RST_CYC) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int k = 0; k < NP; k++) begin
			fork
				automatic int kk = k;
				run_requester(kk);
			join_none
		end
		wait (finished == NP);
		repeat (2) @(posedge clk);
		check_value("transfer count", xfer_count, NP * XFERS);
		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		repeat (WDOG_CYC) @(posedge clk);
		$display("Timeout: requesters did not finish within %0d cycles", WDOG_CYC);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule
